//--- sources.f
design/path_types_pkg.sv
design/sort_ctrl_pkg.sv
design/octile_distance.sv
design/open_list.sv
design/apb_sort_regs.sv
design/bubble_sort_ctrl.sv
design/astar_sort_top.sv
verification/astar_sort_asserts.sv
verification/tb_astar_sort.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_astar_sort -f sources.f -o sim_astar_sort

status=0
./obj_dir/sim_astar_sort > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation reported a failure."
	exit 1
fi
if ! grep -q "Verification passed" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation ended without passing."
	exit 1
fi
echo "Simulation passed."

//--- verification/tb_astar_sort.sv
module tb_astar_sort;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_NODES   = 32;
	localparam int SORT_RUNS   = 6;
	localparam int CYCLE_LIMIT = 32 * 65 * SORT_RUNS + 3000;

	logic                     Clk = 1'b0;
	logic                     Reset;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	sort_ctrl_pkg::apb_addr_t paddr;
	sort_ctrl_pkg::apb_data_t pwdata;
	sort_ctrl_pkg::apb_data_t prdata;
	logic                     pready;
	logic                     pslverr;

	// Host copy of the list and the expected order.
	logic [7:0] list_x [MAX_NODES];
	logic [7:0] list_y [MAX_NODES];
	logic [7:0] exp_x [MAX_NODES];
	logic [7:0] exp_y [MAX_NODES];
	logic [7:0] goal_x;
	logic [7:0] goal_y;
	logic [7:0] start_x;
	logic [7:0] start_y;
	logic       compare_req;
	int         cycle_count = 0;

	// Ties at cost 30, 140 and 14 around (50,50), plus repeated nodes.
	logic [7:0] tie_x [12] = '{8'd53, 8'd47, 8'd50, 8'd60, 8'd53, 8'd50,
		8'd40, 8'd51, 8'd49, 8'd53, 8'd50, 8'd47};
	logic [7:0] tie_y [12] = '{8'd50, 8'd50, 8'd53, 8'd60, 8'd50, 8'd47,
		8'd40, 8'd51, 8'd49, 8'd50, 8'd50, 8'd53};

	astar_sort_top #(.MAX_NODES(MAX_NODES)) i_dut
	(
		.Clk(Clk), .Reset(Reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr)
	);

	always #5 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
		begin
			$display("Timeout: the sort tests did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("Verification failed");
			$fatal(1, "Run stopped on timeout.");
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "Run stopped at the first mismatch.");
		end
	endtask

	task automatic apb_write(input sort_ctrl_pkg::apb_addr_t addr,
		input sort_ctrl_pkg::apb_data_t data, output logic err);
		@(posedge Clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge Clk);
		#1;
		penable = 1'b1;
		@(negedge Clk);
		err = pslverr;
		check_value("pready", 32'(pready), 32'h1);
		@(posedge Clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input sort_ctrl_pkg::apb_addr_t addr,
		output sort_ctrl_pkg::apb_data_t data);
		@(posedge Clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge Clk);
		#1;
		penable = 1'b1;
		@(negedge Clk);
		data = prdata;
		check_value("pready", 32'(pready), 32'h1);
		check_value("pslverr", 32'(pslverr), 32'h0);
		@(posedge Clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	function automatic sort_ctrl_pkg::apb_addr_t list_addr(input int idx);
		return sort_ctrl_pkg::LIST_BASE + sort_ctrl_pkg::apb_addr_t'(idx * 4);
	endfunction

	task automatic write_reg(input sort_ctrl_pkg::apb_addr_t addr,
		input sort_ctrl_pkg::apb_data_t data);
		logic err;
		apb_write(addr, data, err);
		check_value("pslverr", 32'(err), 32'h0);
	endtask

	task automatic write_node(input int idx, input logic [7:0] x, input logic [7:0] y);
		write_reg(list_addr(idx), {16'h0000, y, x});
		list_x[idx] = x;
		list_y[idx] = y;
	endtask

	task automatic set_points(input logic [7:0] gx, input logic [7:0] gy,
		input logic [7:0] sx, input logic [7:0] sy);
		write_reg(sort_ctrl_pkg::GOAL_OFFSET, {16'h0000, gy, gx});
		write_reg(sort_ctrl_pkg::START_OFFSET, {16'h0000, sy, sx});
		goal_x  = gx;
		goal_y  = gy;
		start_x = sx;
		start_y = sy;
	endtask

	// Straight steps weigh 10, diagonal steps 14.
	function automatic int ref_octile(input logic [7:0] px, input logic [7:0] py,
		input logic [7:0] rx, input logic [7:0] ry);
		int dx;
		int dy;
		int diag;
		dx = int'(px) - int'(rx);
		dy = int'(py) - int'(ry);
		if (dx < 0)
			dx = -dx;
		if (dy < 0)
			dy = -dy;
		diag = (dx < dy) ? dx : dy;
		return 14 * diag + 10 * (dx + dy - 2 * diag);
	endfunction

	// Stable insertion sort of the first count entries.
	function automatic void ref_sort(input int count);
		int         cost [MAX_NODES];
		logic [7:0] kx;
		logic [7:0] ky;
		int         kc;
		int         j;
		for (int i = 0; i < MAX_NODES; i++)
		begin
			exp_x[i] = list_x[i];
			exp_y[i] = list_y[i];
			cost[i]  = ref_octile(list_x[i], list_y[i], goal_x, goal_y)
				+ ref_octile(list_x[i], list_y[i], start_x, start_y);
		end
		for (int i = 1; i < count; i++)
		begin
			kx = exp_x[i];
			ky = exp_y[i];
			kc = cost[i];
			j  = i - 1;
			while (j >= 0 && cost[j] > kc)
			begin
				exp_x[j + 1] = exp_x[j];
				exp_y[j + 1] = exp_y[j];
				cost[j + 1]  = cost[j];
				j--;
			end
			exp_x[j + 1] = kx;
			exp_y[j + 1] = ky;
			cost[j + 1]  = kc;
		end
	endfunction

	function automatic void expect_unchanged();
		for (int i = 0; i < MAX_NODES; i++)
		begin
			exp_x[i] = list_x[i];
			exp_y[i] = list_y[i];
		end
	endfunction

	task automatic compare_now();
		compare_req = 1'b1;
		wait (!compare_req);
		list_x = exp_x;
		list_y = exp_y;
	endtask

	task automatic wait_and_compare();
		sort_ctrl_pkg::apb_data_t rd;
		do
		begin
			apb_read(sort_ctrl_pkg::STATUS_OFFSET, rd);
		end
		while (rd[1] == 1'b0);
		compare_now();
	endtask

	task automatic sort_and_compare();
		write_reg(sort_ctrl_pkg::CTRL_OFFSET, 32'h1);
		wait_and_compare();
	endtask

	// Reads the whole list back against the expected order.
	always
	begin : compare_list
		sort_ctrl_pkg::apb_data_t rd;
		wait (compare_req);
		for (int i = 0; i < MAX_NODES; i++)
		begin
			apb_read(list_addr(i), rd);
			check_value($sformatf("list entry %0d", i), rd, {16'h0000, exp_y[i], exp_x[i]});
		end
		compare_req = 1'b0;
	end

	initial
	begin
		sort_ctrl_pkg::apb_data_t rd;
		logic                     err;
		void'($urandom(32'h8c10));
		Reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		compare_req = 1'b0;
		goal_x      = '0;
		goal_y      = '0;
		start_x     = '0;
		start_y     = '0;
		for (int i = 0; i < MAX_NODES; i++)
		begin
			list_x[i] = '0;
			list_y[i] = '0;
		end
		repeat (10) @(posedge Clk);
		#1;
		Reset = 1'b0;

		// Reset values and an out of range entry.
		apb_read(sort_ctrl_pkg::STATUS_OFFSET, rd);
		check_value("STATUS", rd, 32'h0);
		apb_read(sort_ctrl_pkg::GOAL_OFFSET, rd);
		check_value("GOAL", rd, 32'h0);
		apb_read(sort_ctrl_pkg::START_OFFSET, rd);
		check_value("START", rd, 32'h0);
		apb_read(sort_ctrl_pkg::COUNT_OFFSET, rd);
		check_value("COUNT", rd, 32'h0);
		apb_write(list_addr(MAX_NODES), 32'h0000_0505, err);
		check_value("pslverr", 32'(err), 32'h1);

		// Register and list readback.
		set_points(8'h11, 8'h2A, 8'h33, 8'h07);
		write_reg(sort_ctrl_pkg::COUNT_OFFSET, 32'd5);
		apb_read(sort_ctrl_pkg::GOAL_OFFSET, rd);
		check_value("GOAL", rd, 32'h0000_2A11);
		apb_read(sort_ctrl_pkg::START_OFFSET, rd);
		check_value("START", rd, 32'h0000_0733);
		apb_read(sort_ctrl_pkg::COUNT_OFFSET, rd);
		check_value("COUNT", rd, 32'd5);
		for (int i = 0; i < 5; i++)
			write_node(i, 8'($urandom), 8'($urandom));
		write_node(MAX_NODES - 1, 8'hA5, 8'h5A);
		expect_unchanged();
		compare_now();

		// Random list of 20 nodes.
		set_points(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
		write_reg(sort_ctrl_pkg::COUNT_OFFSET, 32'd20);
		for (int i = 0; i < 20; i++)
			write_node(i, 8'($urandom), 8'($urandom));
		ref_sort(20);
		sort_and_compare();

		// Ties keep their order, then a sorted list stays as it is.
		set_points(8'd50, 8'd50, 8'd50, 8'd50);
		write_reg(sort_ctrl_pkg::COUNT_OFFSET, 32'd12);
		for (int i = 0; i < 12; i++)
			write_node(i, tie_x[i], tie_y[i]);
		ref_sort(12);
		sort_and_compare();
		expect_unchanged();
		sort_and_compare();

		// Writes are rejected while the sort runs.
		set_points(8'd0, 8'd0, 8'd0, 8'd0);
		write_reg(sort_ctrl_pkg::COUNT_OFFSET, 32'd20);
		for (int i = 0; i < 20; i++)
			write_node(i, 8'(200 - 10 * i), 8'(i));
		ref_sort(20);
		write_reg(sort_ctrl_pkg::CTRL_OFFSET, 32'h1);
		apb_read(sort_ctrl_pkg::STATUS_OFFSET, rd);
		check_value("STATUS", rd, 32'h1);
		apb_write(sort_ctrl_pkg::GOAL_OFFSET, 32'h0000_4444, err);
		check_value("pslverr", 32'(err), 32'h1);
		apb_write(list_addr(3), 32'h0000_7777, err);
		check_value("pslverr", 32'(err), 32'h1);
		wait_and_compare();
		apb_read(sort_ctrl_pkg::GOAL_OFFSET, rd);
		check_value("GOAL", rd, 32'h0);

		// Counts of one and zero.
		write_node(0, 8'd200, 8'd0);
		write_node(1, 8'd10, 8'd0);
		write_reg(sort_ctrl_pkg::COUNT_OFFSET, 32'd1);
		expect_unchanged();
		sort_and_compare();
		write_reg(sort_ctrl_pkg::COUNT_OFFSET, 32'd0);
		expect_unchanged();
		sort_and_compare();

		$display("Verification passed");
		$finish;
	end

endmodule

//--- verification/astar_sort_asserts.sv
module astar_sort_asserts
(
	input logic Clk,
	input logic Reset,
	input logic busy,
	input logic done,
	input logic psel,
	input logic penable,
	input logic pslverr
);

	timeunit 1ns;
	timeprecision 100ps;

	busy_done_exclusive: assert property (@(posedge Clk) disable iff (Reset)
		!(busy && done))
		else $error("busy and done are high together");

	// Errors belong to the access phase only.
	slverr_in_access: assert property (@(posedge Clk) disable iff (Reset)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an access phase");

	done_ends_busy: assert property (@(posedge Clk) disable iff (Reset)
		$rose(done) |-> $fell(busy))
		else $error("done rose without busy falling");

endmodule

bind astar_sort_top astar_sort_asserts i_asserts
(
	.Clk(Clk), .Reset(Reset), .busy(busy), .done(done),
	.psel(psel), .penable(penable), .pslverr(pslverr)
);

//--- design/astar_sort_top.sv
module astar_sort_top
#(
	parameter  int MAX_NODES = 32,
	localparam int IDX_W     = $clog2(MAX_NODES),
	localparam int CNT_W     = $clog2(MAX_NODES + 1)
)
(
	input  logic                     Clk,
	input  logic                     Reset,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  sort_ctrl_pkg::apb_addr_t paddr,
	input  sort_ctrl_pkg::apb_data_t pwdata,
	output sort_ctrl_pkg::apb_data_t prdata,
	output logic                     pready,
	output logic                     pslverr
);

	logic                   busy;
	logic                   done;
	logic                   sort_start;
	logic [CNT_W-1:0]       node_count;
	logic                   host_wr_en;
	logic [IDX_W-1:0]       host_idx;
	path_types_pkg::coord_t host_x;
	path_types_pkg::coord_t host_y;
	path_types_pkg::coord_t host_rd_x;
	path_types_pkg::coord_t host_rd_y;
	path_types_pkg::coord_t goal_x;
	path_types_pkg::coord_t goal_y;
	path_types_pkg::coord_t start_x;
	path_types_pkg::coord_t start_y;
	logic [IDX_W-1:0]       pair_idx;
	logic                   swap_en;
	path_types_pkg::coord_t a_x;
	path_types_pkg::coord_t a_y;
	path_types_pkg::coord_t b_x;
	path_types_pkg::coord_t b_y;
	path_types_pkg::dist_t  goal_dist_a;
	path_types_pkg::dist_t  goal_dist_b;
	path_types_pkg::dist_t  start_dist_a;
	path_types_pkg::dist_t  start_dist_b;

	apb_sort_regs #(.MAX_NODES(MAX_NODES)) i_regs
	(
		.Clk(Clk), .Reset(Reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done),
		.host_rd_x(host_rd_x), .host_rd_y(host_rd_y),
		.host_wr_en(host_wr_en), .host_idx(host_idx),
		.host_x(host_x), .host_y(host_y),
		.goal_x(goal_x), .goal_y(goal_y),
		.start_x(start_x), .start_y(start_y),
		.node_count(node_count), .sort_start(sort_start)
	);

	open_list #(.MAX_NODES(MAX_NODES)) i_list
	(
		.Clk(Clk), .Reset(Reset),
		.host_wr_en(host_wr_en), .host_idx(host_idx),
		.host_x(host_x), .host_y(host_y),
		.host_rd_x(host_rd_x), .host_rd_y(host_rd_y),
		.pair_idx(pair_idx), .swap_en(swap_en),
		.a_x(a_x), .a_y(a_y), .b_x(b_x), .b_y(b_y)
	);

	// Distance to the goal.
	octile_distance i_goal_cost
	(
		.Clk(Clk), .Reset(Reset),
		.ref_x(goal_x), .ref_y(goal_y),
		.a_x(a_x), .a_y(a_y), .b_x(b_x), .b_y(b_y),
		.dist_a(goal_dist_a), .dist_b(goal_dist_b)
	);

	// Distance back to the start.
	octile_distance i_start_cost
	(
		.Clk(Clk), .Reset(Reset),
		.ref_x(start_x), .ref_y(start_y),
		.a_x(a_x), .a_y(a_y), .b_x(b_x), .b_y(b_y),
		.dist_a(start_dist_a), .dist_b(start_dist_b)
	);

	bubble_sort_ctrl #(.MAX_NODES(MAX_NODES)) i_ctrl
	(
		.Clk(Clk), .Reset(Reset),
		.sort_start(sort_start), .node_count(node_count),
		.goal_dist_a(goal_dist_a), .goal_dist_b(goal_dist_b),
		.start_dist_a(start_dist_a), .start_dist_b(start_dist_b),
		.pair_idx(pair_idx), .swap_en(swap_en),
		.busy(busy), .done(done)
	);

endmodule

//--- design/bubble_sort_ctrl.sv
module bubble_sort_ctrl
#(
	parameter  int MAX_NODES = 32,
	localparam int IDX_W     = $clog2(MAX_NODES),
	localparam int CNT_W     = $clog2(MAX_NODES + 1)
)
(
	input  logic                  Clk,
	input  logic                  Reset,
	input  logic                  sort_start,
	input  logic [CNT_W-1:0]      node_count,
	input  path_types_pkg::dist_t goal_dist_a,
	input  path_types_pkg::dist_t goal_dist_b,
	input  path_types_pkg::dist_t start_dist_a,
	input  path_types_pkg::dist_t start_dist_b,
	output logic [IDX_W-1:0]      pair_idx,
	output logic                  swap_en,
	output logic                  busy,
	output logic                  done
);

	sort_ctrl_pkg::sort_state_e state;
	path_types_pkg::cost_t      cost_a;
	path_types_pkg::cost_t      cost_b;
	logic                       pass_swapped;
	logic                       last_pair;

	assign cost_a = path_types_pkg::cost_t'(goal_dist_a) + path_types_pkg::cost_t'(start_dist_a);
	assign cost_b = path_types_pkg::cost_t'(goal_dist_b) + path_types_pkg::cost_t'(start_dist_b);

	// Strictly greater, so equal costs stay put.
	assign swap_en = (state == sort_ctrl_pkg::COMPARE) && (cost_a > cost_b);

	assign last_pair = (CNT_W'(pair_idx) + CNT_W'(2)) == node_count;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state        <= sort_ctrl_pkg::IDLE;
			pair_idx     <= '0;
			pass_swapped <= 1'b0;
			busy         <= 1'b0;
			done         <= 1'b0;
		end
		else
		begin
			case (state)
				sort_ctrl_pkg::IDLE:
				begin
					if (sort_start)
					begin
						busy         <= 1'b1;
						done         <= 1'b0;
						pair_idx     <= '0;
						pass_swapped <= 1'b0;
						// Nothing to compare below two nodes.
						if (node_count < 2)
							state <= sort_ctrl_pkg::PASS_END;
						else
							state <= sort_ctrl_pkg::LOAD_PAIR;
					end
				end
				sort_ctrl_pkg::LOAD_PAIR:
				begin
					// Cost units register the pair on this edge.
					state <= sort_ctrl_pkg::COMPARE;
				end
				sort_ctrl_pkg::COMPARE:
				begin
					if (swap_en)
						pass_swapped <= 1'b1;
					if (last_pair)
						state <= sort_ctrl_pkg::PASS_END;
					else
					begin
						pair_idx <= pair_idx + 1'b1;
						state    <= sort_ctrl_pkg::LOAD_PAIR;
					end
				end
				sort_ctrl_pkg::PASS_END:
				begin
					if (pass_swapped)
					begin
						pair_idx     <= '0;
						pass_swapped <= 1'b0;
						state        <= sort_ctrl_pkg::LOAD_PAIR;
					end
					else
					begin
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= sort_ctrl_pkg::IDLE;
					end
				end
				default:
				begin
					state <= sort_ctrl_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/apb_sort_regs.sv
module apb_sort_regs
#(
	parameter  int MAX_NODES = 32,
	localparam int IDX_W     = $clog2(MAX_NODES),
	localparam int CNT_W     = $clog2(MAX_NODES + 1)
)
(
	input  logic                      Clk,
	input  logic                      Reset,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  sort_ctrl_pkg::apb_addr_t  paddr,
	input  sort_ctrl_pkg::apb_data_t  pwdata,
	output sort_ctrl_pkg::apb_data_t  prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      busy,
	input  logic                      done,
	input  path_types_pkg::coord_t    host_rd_x,
	input  path_types_pkg::coord_t    host_rd_y,
	output logic                      host_wr_en,
	output logic [IDX_W-1:0]          host_idx,
	output path_types_pkg::coord_t    host_x,
	output path_types_pkg::coord_t    host_y,
	output path_types_pkg::coord_t    goal_x,
	output path_types_pkg::coord_t    goal_y,
	output path_types_pkg::coord_t    start_x,
	output path_types_pkg::coord_t    start_y,
	output logic [CNT_W-1:0]          node_count,
	output logic                      sort_start
);

	logic                     wr_access;
	logic                     wr_ok;
	logic                     list_hit;
	logic                     list_in_range;
	sort_ctrl_pkg::apb_addr_t list_off;

	// No wait states.
	assign pready = 1'b1;

	assign wr_access     = psel && penable && pwrite;
	assign list_off      = paddr - sort_ctrl_pkg::LIST_BASE;
	assign list_hit      = (paddr >= sort_ctrl_pkg::LIST_BASE) && (paddr[1:0] == 2'b00);
	assign list_in_range = list_hit && (list_off[11:2] < MAX_NODES);

	// Writes bounce while sorting or past the end of the list.
	assign pslverr = wr_access && (busy || (list_hit && !list_in_range));
	assign wr_ok   = wr_access && !pslverr;

	assign host_wr_en = wr_ok && list_in_range;
	assign host_idx   = list_off[IDX_W+1:2];
	assign host_x     = pwdata[7:0];
	assign host_y     = pwdata[15:8];

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			goal_x     <= '0;
			goal_y     <= '0;
			start_x    <= '0;
			start_y    <= '0;
			node_count <= '0;
			sort_start <= 1'b0;
		end
		else
		begin
			sort_start <= wr_ok && (paddr == sort_ctrl_pkg::CTRL_OFFSET) && pwdata[0];
			if (wr_ok)
			begin
				case (paddr)
					sort_ctrl_pkg::GOAL_OFFSET:
					begin
						goal_x <= pwdata[7:0];
						goal_y <= pwdata[15:8];
					end
					sort_ctrl_pkg::START_OFFSET:
					begin
						start_x <= pwdata[7:0];
						start_y <= pwdata[15:8];
					end
					sort_ctrl_pkg::COUNT_OFFSET:
					begin
						// Clamped to the list capacity.
						if (pwdata > MAX_NODES)
							node_count <= CNT_W'(MAX_NODES);
						else
							node_count <= pwdata[CNT_W-1:0];
					end
					default:
					begin
					end
				endcase
			end
		end
	end

	always_comb
	begin
		prdata = '0;
		if (list_in_range)
			prdata = {16'h0000, host_rd_y, host_rd_x};
		else
		begin
			case (paddr)
				sort_ctrl_pkg::STATUS_OFFSET: prdata = {30'h0, done, busy};
				sort_ctrl_pkg::GOAL_OFFSET:   prdata = {16'h0000, goal_y, goal_x};
				sort_ctrl_pkg::START_OFFSET:  prdata = {16'h0000, start_y, start_x};
				sort_ctrl_pkg::COUNT_OFFSET:  prdata = sort_ctrl_pkg::apb_data_t'(node_count);
				default:                      prdata = '0;
			endcase
		end
	end

endmodule

//--- design/open_list.sv
module open_list
#(
	parameter  int MAX_NODES = 32,
	localparam int IDX_W     = $clog2(MAX_NODES)
)
(
	input  logic                   Clk,
	input  logic                   Reset,
	input  logic                   host_wr_en,
	input  logic [IDX_W-1:0]       host_idx,
	input  path_types_pkg::coord_t host_x,
	input  path_types_pkg::coord_t host_y,
	output path_types_pkg::coord_t host_rd_x,
	output path_types_pkg::coord_t host_rd_y,
	input  logic [IDX_W-1:0]       pair_idx,
	input  logic                   swap_en,
	output path_types_pkg::coord_t a_x,
	output path_types_pkg::coord_t a_y,
	output path_types_pkg::coord_t b_x,
	output path_types_pkg::coord_t b_y
);

	path_types_pkg::coord_t x_mem [MAX_NODES];
	path_types_pkg::coord_t y_mem [MAX_NODES];
	logic [IDX_W-1:0]       pair_next;

	assign pair_next = pair_idx + 1'b1;

	// Adjacent pair seen by the cost units.
	assign a_x = x_mem[pair_idx];
	assign a_y = y_mem[pair_idx];
	assign b_x = x_mem[pair_next];
	assign b_y = y_mem[pair_next];

	assign host_rd_x = x_mem[host_idx];
	assign host_rd_y = y_mem[host_idx];

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			for (int i = 0; i < MAX_NODES; i++)
			begin
				x_mem[i] <= '0;
				y_mem[i] <= '0;
			end
		end
		else if (swap_en)
		begin
			x_mem[pair_idx]  <= x_mem[pair_next];
			x_mem[pair_next] <= x_mem[pair_idx];
			y_mem[pair_idx]  <= y_mem[pair_next];
			y_mem[pair_next] <= y_mem[pair_idx];
		end
		else if (host_wr_en)
		begin
			x_mem[host_idx] <= host_x;
			y_mem[host_idx] <= host_y;
		end
	end

endmodule

//--- design/octile_distance.sv
module octile_distance
(
	input  logic                   Clk,
	input  logic                   Reset,
	input  path_types_pkg::coord_t ref_x,
	input  path_types_pkg::coord_t ref_y,
	input  path_types_pkg::coord_t a_x,
	input  path_types_pkg::coord_t a_y,
	input  path_types_pkg::coord_t b_x,
	input  path_types_pkg::coord_t b_y,
	output path_types_pkg::dist_t  dist_a,
	output path_types_pkg::dist_t  dist_b
);

	// Diagonal steps cover the smaller axis, straight steps the rest.
	function automatic path_types_pkg::dist_t octile
	(
		input path_types_pkg::coord_t rx,
		input path_types_pkg::coord_t ry,
		input path_types_pkg::coord_t px,
		input path_types_pkg::coord_t py
	);
		path_types_pkg::coord_t dx;
		path_types_pkg::coord_t dy;
		path_types_pkg::coord_t hi;
		path_types_pkg::coord_t lo;
		dx = (px > rx) ? px - rx : rx - px;
		dy = (py > ry) ? py - ry : ry - py;
		hi = (dx > dy) ? dx : dy;
		lo = (dx > dy) ? dy : dx;
		return path_types_pkg::dist_t'(path_types_pkg::STRAIGHT_COST * hi
			+ (path_types_pkg::DIAGONAL_COST - path_types_pkg::STRAIGHT_COST) * lo);
	endfunction

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			dist_a <= '0;
			dist_b <= '0;
		end
		else
		begin
			dist_a <= octile(ref_x, ref_y, a_x, a_y);
			dist_b <= octile(ref_x, ref_y, b_x, b_y);
		end
	end

endmodule

//--- design/sort_ctrl_pkg.sv
package sort_ctrl_pkg;

	// Pass and compare states of the sort.
	typedef enum logic [1:0]
	{
		IDLE,
		LOAD_PAIR,
		COMPARE,
		PASS_END
	} sort_state_e;

	typedef logic [11:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Bit 0 starts a sort.
	localparam apb_addr_t CTRL_OFFSET   = 12'h000;
	// Bit 0 busy, bit 1 done.
	localparam apb_addr_t STATUS_OFFSET = 12'h004;
	// X in bits 7:0, y in bits 15:8.
	localparam apb_addr_t GOAL_OFFSET   = 12'h008;
	localparam apb_addr_t START_OFFSET  = 12'h00C;
	localparam apb_addr_t COUNT_OFFSET  = 12'h010;

	// One word per node from here on.
	localparam apb_addr_t LIST_BASE     = 12'h100;

endpackage

//--- design/path_types_pkg.sv
package path_types_pkg;

	// One axis of a grid position.
	typedef logic [7:0] coord_t;

	// Octile distance of one node to one point, at most 3570.
	typedef logic [11:0] dist_t;

	// Goal distance plus start distance.
	typedef logic [12:0] cost_t;

	// Step weights, ten for straight and fourteen for diagonal.
	localparam int STRAIGHT_COST = 10;
	localparam int DIAGONAL_COST = 14;

endpackage
